// ==== all.f ====
+incdir+rtl
rtl/mipsPkg.sv
rtl/aluSliceIf.sv
rtl/pcUnit.sv
rtl/mainDecoder.sv
rtl/regFile.sv
rtl/aluOperands.sv
rtl/aluSlice.sv
rtl/aluResolve.sv
rtl/mipsCore.sv
tests/mipsCore_chk.sv
tests/mipsCoreTb.sv

// ==== tests/mipsCoreTb.sv ====
`default_nettype none
`include "mips_config.svh"

module mipsCoreTb;

    localparam int MEM_WORDS  = 64;
    localparam int WAIT_LIMIT = 200; // Cycles per run before giving up

    // MIPS encodings
    localparam logic [5:0] opLw  = 6'h23;
    localparam logic [5:0] opSw  = 6'h2B;
    localparam logic [5:0] opBeq = 6'h04;
    localparam logic [5:0] opBne = 6'h05;
    localparam logic [5:0] opJ   = 6'h02;
    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr  = 6'h25;
    localparam logic [5:0] fnSlt = 6'h2A;
    localparam logic [31:0] haltInstr = {opBeq, 5'd0, 5'd0, 16'hFFFF}; // beq r0,r0,-1

    logic              Clk;
    logic              rst;
    logic [`XLEN-1:0]  instrAddr;
    logic [`XLEN-1:0]  instr;
    logic [`XLEN-1:0]  dataAddr;
    logic [`XLEN-1:0]  dataWData;
    logic              dataWrite;
    logic              dataRead;
    logic [`XLEN-1:0]  dataRData;

    logic [`XLEN-1:0] imem [MEM_WORDS];
    logic [`XLEN-1:0] dmem [MEM_WORDS]; // Word addressed
    logic [`XLEN-1:0] logAddr [$];      // One entry per store
    logic [`XLEN-1:0] logData [$];
    int               errors;
    int               checks;

    mipsCore dut0 (
        .Clk       (Clk),
        .rst       (rst),
        .instrAddr (instrAddr),
        .instr     (instr),
        .dataAddr  (dataAddr),
        .dataWData (dataWData),
        .dataWrite (dataWrite),
        .dataRead  (dataRead),
        .dataRData (dataRData)
    );

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    // Instruction ROM, zero outside the array
    always_comb begin
        if ($isunknown(instrAddr) || instrAddr >= 4 * MEM_WORDS) begin
            instr = '0;
        end else begin
            instr = imem[instrAddr[7:2]];
        end
    end

    // Read data valid in the same cycle as dataRead
    always_comb begin
        if (dataRead !== 1'b1 || $isunknown(dataAddr) || dataAddr >= 4 * MEM_WORDS) begin
            dataRData = '0;
        end else begin
            dataRData = dmem[dataAddr[7:2]];
        end
    end

    always @(posedge Clk) begin
        if (dataWrite === 1'b1) begin
            logAddr.push_back(dataAddr);
            logData.push_back(dataWData);
            if (dataAddr < 4 * MEM_WORDS) begin
                dmem[dataAddr[7:2]] <= dataWData;
            end
        end
    end

    function automatic logic [31:0] rType(input int rs, input int rt, input int rd,
                                          input logic [5:0] fn);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input int rs, input int rt,
                                          input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic checkStore(input string name, input int idx, input logic [31:0] expAddr,
                              input logic [31:0] expData);
        if (idx >= logAddr.size()) begin
            $display("store %s missing from the store log", name);
            errors++;
        end else begin
            checkValue({name, " address"}, expAddr, logAddr[idx]);
            checkValue({name, " data"}, expData, logData[idx]);
        end
    endtask

    // Holds rst across one edge so the PC sits at 0 before the ROM changes
    task automatic enterReset();
        rst = 1'b1;
        @(posedge Clk);
        #1;
        logAddr.delete();
        logData.delete();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
    endtask

    task automatic leaveReset();
        repeat (9) @(posedge Clk); // 10 reset cycles in total
        #1;
        checkValue("reset instrAddr", 32'h0, instrAddr);
        checkValue("reset store count", 32'h0, logAddr.size());
        rst = 1'b0;
        @(posedge Clk);
        #1;
        checkValue("first instruction instrAddr", 32'h4, instrAddr); // One clock per instruction
    endtask

    task automatic waitForAddr(input logic [31:0] target, input string name);
        int cyc;
        cyc = 0;
        while (instrAddr !== target && cyc < WAIT_LIMIT) begin
            @(posedge Clk);
            #1;
            cyc++;
        end
        if (instrAddr !== target) begin
            $display("timeout: %s never reached instrAddr %h", name, target);
            errors++;
        end
    endtask

    task automatic aluPair(input logic [31:0] a, input logic [31:0] b);
        logic [31:0] expected [5];
        string       opNames [5];
        opNames     = '{"add", "sub", "and", "or", "slt"};
        expected[0] = a + b;
        expected[1] = a - b;
        expected[2] = a & b;
        expected[3] = a | b;
        expected[4] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        enterReset();
        imem[0] = iType(opLw, 0, 1, 16'd0);
        imem[1] = iType(opLw, 0, 2, 16'd4);
        imem[2] = rType(1, 2, 3, fnAdd);
        imem[3] = rType(1, 2, 4, fnSub);
        imem[4] = rType(1, 2, 5, fnAnd);
        imem[5] = rType(1, 2, 6, fnOr);
        imem[6] = rType(1, 2, 7, fnSlt);
        for (int i = 0; i < 5; i++) begin
            imem[7 + i] = iType(opSw, 0, 3 + i, 16'(8 + 4 * i)); // r3..r7 to 8..24
        end
        imem[12] = haltInstr;
        dmem[0]  = a;
        dmem[1]  = b;
        leaveReset();
        waitForAddr(32'd48, "alu program");
        checkValue($sformatf("alu %h,%h store count", a, b), 32'd5, logAddr.size());
        for (int i = 0; i < 5; i++) begin
            checkStore($sformatf("%s %h,%h", opNames[i], a, b), i, 32'(8 + 4 * i), expected[i]);
        end
    endtask

    // r6 still holds the OR result of the previous program until reset clears it
    task automatic resetStoreTest();
        enterReset();
        imem[0] = iType(opSw, 0, 6, 16'd60); // Store pending at PC 0 for all of reset
        imem[1] = haltInstr;
        leaveReset();
        waitForAddr(32'd4, "reset program");
        checkValue("reset program store count", 32'd1, logAddr.size());
        checkStore("first instruction", 0, 32'd60, 32'd0);
    endtask

    task automatic loadStoreTest();
        logic [31:0] base;
        logic [31:0] value;
        logic [15:0] offStore;
        logic [15:0] offCopy;
        base     = 32'h40;
        value    = $urandom();
        offStore = 16'hFFF8; // -8
        offCopy  = 16'hFFFC; // -4
        enterReset();
        imem[0] = iType(opLw, 0, 1, 16'd0); // Base register
        imem[1] = iType(opLw, 0, 2, 16'd4);
        imem[2] = iType(opSw, 1, 2, offStore);
        imem[3] = iType(opLw, 1, 3, offStore); // Reload
        imem[4] = iType(opSw, 1, 3, offCopy);
        imem[5] = haltInstr;
        dmem[0] = base;
        dmem[1] = value;
        leaveReset();
        waitForAddr(32'd20, "load/store program");
        checkValue("load/store store count", 32'd2, logAddr.size());
        checkStore("sw negative offset", 0, base + {{16{offStore[15]}}, offStore}, value);
        checkStore("lw round trip", 1, base + {{16{offCopy[15]}}, offCopy}, value);
    endtask

    task automatic branchEqTest(input logic equal);
        logic [31:0] a;
        logic [31:0] b;
        a = $urandom();
        b = equal ? a : a ^ 32'h0001_0000;
        enterReset();
        imem[0] = iType(opLw, 0, 1, 16'd0);
        imem[1] = iType(opLw, 0, 2, 16'd4);
        imem[2] = iType(opBeq, 1, 2, 16'd2); // Target 8 + 4 + 2 * 4 = 20
        imem[3] = iType(opSw, 0, 1, 16'd32);
        imem[4] = iType(opSw, 0, 1, 16'd36);
        imem[5] = iType(opSw, 0, 2, 16'd40);
        imem[6] = haltInstr;
        dmem[0] = a;
        dmem[1] = b;
        leaveReset();
        waitForAddr(32'd24, "beq program");
        if (equal) begin
            checkValue("beq taken store count", 32'd1, logAddr.size());
            checkStore("beq target", 0, 32'd40, b);
        end else begin
            checkValue("beq not taken store count", 32'd3, logAddr.size());
            checkStore("beq fall through", 0, 32'd32, a);
            checkStore("beq second marker", 1, 32'd36, a);
            checkStore("beq end marker", 2, 32'd40, b);
        end
    endtask

    task automatic branchNeJumpTest(input logic equal);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] jumpPc4;
        logic [31:0] jumpTarget;
        a = $urandom();
        b = equal ? a : ~a;
        jumpPc4    = 32'd24; // Address after the j at 20
        jumpTarget = {jumpPc4[31:28], 26'(64 >> 2), 2'b00}; // PC+4 upper bits, index
        enterReset();
        imem[0]  = iType(opLw, 0, 1, 16'd0);
        imem[1]  = iType(opLw, 0, 2, 16'd4);
        imem[2]  = iType(opBne, 1, 2, 16'd1); // Target 16
        imem[3]  = iType(opSw, 0, 1, 16'd40);
        imem[4]  = iType(opSw, 0, 2, 16'd44);
        imem[5]  = {opJ, 26'(64 >> 2)};
        imem[6]  = iType(opSw, 0, 2, 16'd52); // Never reached
        imem[16] = haltInstr;
        dmem[0]  = a;
        dmem[1]  = b;
        leaveReset();
        waitForAddr(jumpTarget, "j target");
        if (equal) begin
            checkValue("bne not taken store count", 32'd2, logAddr.size());
            checkStore("bne fall through", 0, 32'd40, a);
            checkStore("bne end marker", 1, 32'd44, b);
        end else begin
            checkValue("bne taken store count", 32'd1, logAddr.size());
            checkStore("bne target", 0, 32'd44, b);
        end
    endtask

    initial begin
        void'($urandom(4));
        rst    = 1'b1;
        errors = 0;
        checks = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end

        repeat (20) aluPair($urandom(), $urandom());
        aluPair(32'h1234_5678, 32'h1234_5678); // Equal
        aluPair(32'h8000_0000, 32'h0000_0001); // Sign difference
        aluPair(32'h0000_0001, 32'h8000_0000);
        aluPair(32'h7FFF_FFFF, 32'h8000_0000); // SLT across an overflow
        aluPair(32'hFFFF_FFFF, 32'hFFFF_FFFF);
        aluPair(32'hFFFF_FFFF, 32'h0000_0001); // Carry through all slices

        resetStoreTest();
        loadStoreTest();
        branchEqTest(1'b1);
        branchEqTest(1'b0);
        branchNeJumpTest(1'b1);
        branchNeJumpTest(1'b0);

        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut0.chk0.failCount);
        if (errors == 0 && dut0.chk0.failCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/mipsCore_chk.sv ====
`default_nettype none
`include "mips_config.svh"

module mipsCore_chk (
    input logic              Clk,
    input logic              rst,
    input logic [`XLEN-1:0]  instrAddr,
    input logic              dataWrite,
    input logic              dataRead
);

    int failCount = 0; // Read by the testbench at the end of the run

    // PC is cleared by the synchronous reset
    resetPc: assert property (@(posedge Clk) rst |=> instrAddr == '0)
        else begin
            $error("instrAddr not zero after a reset cycle");
            failCount++;
        end

    noStoreInReset: assert property (@(posedge Clk) rst |-> !dataWrite)
        else begin
            $error("dataWrite high during reset");
            failCount++;
        end

    wordAligned: assert property (@(posedge Clk) disable iff (rst) instrAddr[1:0] == 2'b00)
        else begin
            $error("instrAddr not word aligned");
            failCount++;
        end

    // lw and sw are exclusive opcodes
    readXorWrite: assert property (@(posedge Clk) !(dataWrite && dataRead))
        else begin
            $error("dataWrite and dataRead high together");
            failCount++;
        end

endmodule

bind mipsCore mipsCore_chk chk0 (
    .Clk       (Clk),
    .rst       (rst),
    .instrAddr (instrAddr),
    .dataWrite (dataWrite),
    .dataRead  (dataRead)
);

`default_nettype wire

// ==== rtl/mipsCore.sv ====
`default_nettype none
`include "mips_config.svh"

module mipsCore (
    input  logic              Clk,
    input  logic              rst,
    output logic [`XLEN-1:0]  instrAddr,
    input  logic [`XLEN-1:0]  instr,
    output logic [`XLEN-1:0]  dataAddr,
    output logic [`XLEN-1:0]  dataWData,
    output logic              dataWrite,
    output logic              dataRead,
    input  logic [`XLEN-1:0]  dataRData
);

    mipsPkg::ctrlWordT       ctrl;
    mipsPkg::aluOpE          aluOp;
    logic [`XLEN-1:0]        rdDataA;
    logic [`XLEN-1:0]        rdDataB;
    logic [`XLEN-1:0]        aluResult;
    logic                    zero;
    logic [`REG_ADDR_W-1:0]  wrAddr;
    logic [`XLEN-1:0]        wrData;

    aluSliceIf aluBus ();

    assign wrAddr = ctrl.regDst ? instr[15:11] : instr[20:16]; // rd for R-type, rt for lw
    assign wrData = ctrl.memToReg ? dataRData : aluResult;     // Write-back select

    assign dataAddr  = aluResult; // base + offset
    assign dataWData = rdDataB;   // rt
    assign dataWrite = ctrl.memWrite & ~rst; // No stores while in reset
    assign dataRead  = ctrl.memRead;

    pcUnit pc0 (
        .Clk       (Clk),
        .rst       (rst),
        .instr     (instr),
        .ctrl      (ctrl),
        .zero      (zero),
        .instrAddr (instrAddr)
    );

    mainDecoder dec0 (
        .instr (instr),
        .ctrl  (ctrl),
        .aluOp (aluOp)
    );

    regFile rf0 (
        .Clk     (Clk),
        .rst     (rst),
        .rdAddrA (instr[25:21]), // rs
        .rdAddrB (instr[20:16]), // rt
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .wrEn    (ctrl.regWrite),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

    aluOperands opnd0 (
        .rdDataB   (rdDataB),
        .immediate (instr[15:0]),
        .aluSrc    (ctrl.aluSrc),
        .aluOp     (aluOp),
        .opA       (rdDataA),
        .bus       (aluBus.feed)
    );

    for (genvar i = 0; i < `ALU_SLICES; i++) begin : gSlice
        aluSlice #(.index(i)) slice0 (
            .bus (aluBus.slice)
        );
    end

    aluResolve res0 (
        .bus       (aluBus.drain),
        .aluOp     (aluOp),
        .aluResult (aluResult),
        .zero      (zero)
    );

endmodule

`default_nettype wire

// ==== rtl/aluResolve.sv ====
`default_nettype none
`include "mips_config.svh"

module aluResolve (
    aluSliceIf.drain          bus,
    input  mipsPkg::aluOpE    aluOp,
    output logic [`XLEN-1:0]  aluResult,
    output logic              zero
);

    logic [`ALU_SLICES-1:0] carryIn;
    logic [`XLEN-1:0]       sum;
    logic                   aMsb;
    logic                   bMsb;
    logic                   overflow;
    logic                   slt;

    // Each slice carry as a flat sum of products over lower slices
    always_comb begin
        logic c;
        logic pRun; // Propagate product of the slices in between

        for (int i = 0; i < `ALU_SLICES; i++) begin
            c    = 1'b0;
            pRun = 1'b1;
            for (int j = i - 1; j >= 0; j--) begin
                c    = c | (bus.gBlk[j] & pRun);
                pRun = pRun & bus.pBlk[j];
            end
            carryIn[i] = c | (pRun & bus.cin0);
        end
    end

    assign bus.cin = carryIn;

    assign sum  = bus.sumNib;
    assign aMsb = bus.aNib[`ALU_SLICES-1][`SLICE_W-1];
    assign bMsb = bus.bNib[`ALU_SLICES-1][`SLICE_W-1]; // Inverted B for SLT

    // Same operand signs but the sum sign differs
    assign overflow = (aMsb == bMsb) && (sum[`XLEN-1] != aMsb);
    assign slt      = sum[`XLEN-1] ^ overflow; // Signed A < B

    always_comb begin
        case (aluOp)
            mipsPkg::ALU_AND: aluResult = bus.andNib;
            mipsPkg::ALU_OR:  aluResult = bus.orNib;
            mipsPkg::ALU_ADD: aluResult = sum;
            mipsPkg::ALU_SUB: aluResult = sum;
            mipsPkg::ALU_SLT: aluResult = {{(`XLEN-1){1'b0}}, slt};
            default:          aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0); // Drives beq/bne

endmodule

`default_nettype wire

// ==== rtl/aluSlice.sv ====
`default_nettype none
`include "mips_config.svh"

module aluSlice #(
    parameter int index = 0
) (
    aluSliceIf.slice bus
);

    logic [`SLICE_W-1:0] a;
    logic [`SLICE_W-1:0] b;
    logic [`SLICE_W-1:0] g; // Bit generate
    logic [`SLICE_W-1:0] p; // Bit propagate
    logic [`SLICE_W-1:0] c; // Carry into each bit

    assign a = bus.aNib[index];
    assign b = bus.bNib[index];

    assign g = a & b;
    assign p = a | b;

    // Lookahead inside the slice, all from the slice carry-in
    assign c[0] = bus.cin[index];
    assign c[1] = g[0] | (p[0] & c[0]);
    assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & c[0]);
    assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
                | (p[2] & p[1] & p[0] & c[0]);

    assign bus.sumNib[index] = a ^ b ^ c;
    assign bus.andNib[index] = g; // AND is the generate term
    assign bus.orNib[index]  = p; // OR is the propagate term

    // Block terms for the second level
    assign bus.gBlk[index] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
                           | (p[3] & p[2] & p[1] & g[0]);
    assign bus.pBlk[index] = &p;

endmodule

`default_nettype wire

// ==== rtl/aluOperands.sv ====
`default_nettype none
`include "mips_config.svh"

module aluOperands (
    input  logic [`XLEN-1:0]  rdDataB,
    input  logic [15:0]       immediate,
    input  logic              aluSrc,
    input  mipsPkg::aluOpE    aluOp,
    input  logic [`XLEN-1:0]  opA,
    aluSliceIf.feed           bus
);

    logic [`XLEN-1:0] immExt;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] opBFinal;
    logic             subtract;

    assign immExt = {{(`XLEN-16){immediate[15]}}, immediate}; // Sign-extend
    assign opB    = aluSrc ? immExt : rdDataB;

    // A - B as A + ~B + 1
    assign subtract = (aluOp == mipsPkg::ALU_SUB) || (aluOp == mipsPkg::ALU_SLT);
    assign opBFinal = subtract ? ~opB : opB;

    // Packed per-slice nibbles, slice 0 holds bits 3:0
    assign bus.aNib = opA;
    assign bus.bNib = opBFinal;
    assign bus.cin0 = subtract;

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
`default_nettype none
`include "mips_config.svh"

module regFile (
    input  logic                    Clk,
    input  logic                    rst,
    input  logic [`REG_ADDR_W-1:0]  rdAddrA,
    input  logic [`REG_ADDR_W-1:0]  rdAddrB,
    input  logic [`REG_ADDR_W-1:0]  wrAddr,
    input  logic [`XLEN-1:0]        wrData,
    input  logic                    wrEn,
    output logic [`XLEN-1:0]        rdDataA,
    output logic [`XLEN-1:0]        rdDataB
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin // r0 is hardwired
            regs[wrAddr] <= wrData;
        end
    end

    // Combinational reads, r0 forced to zero
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

// ==== rtl/mainDecoder.sv ====
`default_nettype none
`include "mips_config.svh"

module mainDecoder (
    input  logic [`XLEN-1:0]   instr,
    output mipsPkg::ctrlWordT  ctrl,
    output mipsPkg::aluOpE     aluOp
);

    mipsPkg::opcodeE opcode;
    mipsPkg::functE  funct;

    assign opcode = mipsPkg::opcodeE'(instr[31:26]);
    assign funct  = mipsPkg::functE'(instr[5:0]);

    always_comb begin
        logic rKnown; // funct is one of the five supported

        ctrl   = '0; // Unknown encodings write nothing
        aluOp  = mipsPkg::ALU_AND;
        rKnown = 1'b1;

        case (opcode)
            mipsPkg::OP_RTYPE: begin
                case (funct)
                    mipsPkg::FN_ADD: aluOp = mipsPkg::ALU_ADD;
                    mipsPkg::FN_SUB: aluOp = mipsPkg::ALU_SUB;
                    mipsPkg::FN_AND: aluOp = mipsPkg::ALU_AND;
                    mipsPkg::FN_OR:  aluOp = mipsPkg::ALU_OR;
                    mipsPkg::FN_SLT: aluOp = mipsPkg::ALU_SLT;
                    default:         rKnown = 1'b0;
                endcase
                ctrl.regDst   = rKnown;
                ctrl.regWrite = rKnown;
            end
            mipsPkg::OP_LW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                aluOp         = mipsPkg::ALU_ADD; // Address calculation
            end
            mipsPkg::OP_SW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                aluOp         = mipsPkg::ALU_ADD;
            end
            mipsPkg::OP_BEQ: begin
                ctrl.beq = 1'b1;
                aluOp    = mipsPkg::ALU_SUB; // Compare via zero flag
            end
            mipsPkg::OP_BNE: begin
                ctrl.bne = 1'b1;
                aluOp    = mipsPkg::ALU_SUB;
            end
            mipsPkg::OP_J: begin
                ctrl.jump = 1'b1;
            end
            default: begin
                ctrl  = '0;
                aluOp = mipsPkg::ALU_AND;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/pcUnit.sv ====
`default_nettype none
`include "mips_config.svh"

module pcUnit (
    input  logic               Clk,
    input  logic               rst,
    input  logic [`XLEN-1:0]   instr,
    input  mipsPkg::ctrlWordT  ctrl,
    input  logic               zero,
    output logic [`XLEN-1:0]   instrAddr
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] branchOff;
    logic [`XLEN-1:0] branchTgt;
    logic [`XLEN-1:0] jumpTgt;
    logic [`XLEN-1:0] pcNext;
    logic             takeBranch;

    assign pcPlus4   = pc + `XLEN'd4;
    assign branchOff = {{(`XLEN-18){instr[15]}}, instr[15:0], 2'b00}; // Sign-extend, word offset
    assign branchTgt = pcPlus4 + branchOff;
    assign jumpTgt   = {pcPlus4[`XLEN-1:`XLEN-4], instr[25:0], 2'b00}; // Pseudo-direct

    // beq on equal, bne on not equal
    assign takeBranch = (ctrl.beq & zero) | (ctrl.bne & ~zero);

    always_comb begin
        if (ctrl.jump) begin
            pcNext = jumpTgt;
        end else if (takeBranch) begin
            pcNext = branchTgt;
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pcNext; // One instruction per clock
        end
    end

    assign instrAddr = pc;

endmodule

`default_nettype wire

// ==== rtl/aluSliceIf.sv ====
`default_nettype none
`include "mips_config.svh"

interface aluSliceIf;

    logic [`ALU_SLICES-1:0][`SLICE_W-1:0] aNib;   // Operand A per slice
    logic [`ALU_SLICES-1:0][`SLICE_W-1:0] bNib;   // Operand B, already inverted for SUB/SLT
    logic [`ALU_SLICES-1:0][`SLICE_W-1:0] sumNib;
    logic [`ALU_SLICES-1:0][`SLICE_W-1:0] andNib;
    logic [`ALU_SLICES-1:0][`SLICE_W-1:0] orNib;
    logic [`ALU_SLICES-1:0]               cin;    // Per-slice carry-in from the lookahead
    logic [`ALU_SLICES-1:0]               gBlk;   // Block generate
    logic [`ALU_SLICES-1:0]               pBlk;   // Block propagate
    logic                                 cin0;   // Carry into bit 0

    modport feed (output aNib, bNib, cin0);

    modport slice (
        input  aNib, bNib, cin,
        output sumNib, andNib, orNib, gBlk, pBlk
    );

    // Needs the operand MSBs for overflow in SLT
    modport drain (
        input  aNib, bNib, cin0, sumNib, andNib, orNib, gBlk, pBlk,
        output cin
    );

endinterface

`default_nettype wire

// ==== rtl/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

    // Major opcodes, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcodeE;

    // R-type functions, instr[5:0]
    typedef enum logic [5:0] {
        FN_ADD = 6'b100000,
        FN_SUB = 6'b100010,
        FN_AND = 6'b100100,
        FN_OR  = 6'b100101,
        FN_SLT = 6'b101010
    } functE;

    // Bit 2 means B is inverted with carry-in set
    typedef enum logic [2:0] {
        ALU_AND = 3'b000,
        ALU_OR  = 3'b001,
        ALU_ADD = 3'b010,
        ALU_SUB = 3'b110,
        ALU_SLT = 3'b111
    } aluOpE;

    typedef struct packed {
        logic aluSrc;   // B from immediate
        logic regDst;   // Write rd instead of rt
        logic memWrite; // sw
        logic memRead;  // lw
        logic beq;
        logic bne;
        logic jump;
        logic memToReg; // Write-back from memory
        logic regWrite;
    } ctrlWordT;

endpackage

`default_nettype wire

// ==== rtl/mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Datapath and address width
`define XLEN 32

// Register file geometry
`define REG_COUNT 32
`define REG_ADDR_W 5

// ALU slicing, one lookahead block per slice
`define SLICE_W 4
`define ALU_SLICES (`XLEN / `SLICE_W)

`endif
